/* sources.f */
logic/controlPkg.sv
logic/instructionDecoder.sv
logic/memoryHandshake.sv
logic/controlSequencer.sv
logic/controlEncoder.sv
logic/controlUnit.sv
verification/controlUnit_chk.sv
verification/controlUnitTb.sv

/* run.sh */
#!/bin/sh
# Builds the control unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module controlUnitTb -f sources.f -o controlUnitSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/controlUnitSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "No errors"; then
	exit 0
fi
echo "Simulation reported failures"
exit 1

/* verification/controlUnitTb.sv */
`default_nettype none

module controlUnitTb import controlPkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	// Instruction runs, including reset, each well under 40 cycles
	localparam int RunCount = 38;
	localparam int CycleLimit = RunCount * 40;
	localparam AluFlags_t NoFlags = '0;

	logic clock;
	logic reset;
	OpCode_t opCode;
	Funct_t funct;
	AluFlags_t flags;
	logic memAck;
	logic memReq;
	ControlWord_t control;
	ControlState_t state;

	int valueErrors = 0;
	int otherErrors = 0;
	int cycleCount = 0;
	logic [31:0] rngState = 32'd50568;

	// One entry per visited state, control word from its first cycle
	ControlState_t pathTrace[$];
	ControlWord_t controlTrace[$];
	ControlWord_t storeControls[$];

	controlUnit dut_i (
		.clock   (clock),
		.reset   (reset),
		.opCode  (opCode),
		.funct   (funct),
		.flags   (flags),
		.memAck  (memAck),
		.memReq  (memReq),
		.control (control),
		.state   (state)
	);

	function automatic logic [31:0] nextRandom();
		rngState ^= rngState << 13;
		rngState ^= rngState >> 17;
		rngState ^= rngState << 5;
		return rngState;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			valueErrors++;
			$display("Fail %s: got %h, expected %h", name, actual, expected);
		end
	endtask

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	initial begin
		while (cycleCount < CycleLimit) begin
			@(posedge clock);
			cycleCount++;
		end
		$display("Run stopped at the cycle limit of %0d cycles", CycleLimit);
		$display("Errors found");
		$finish;
	end

	// Memory side, random answer and release delays of 0 to 3 cycles
	initial begin
		int delay;
		memAck <= 1'b0;
		forever begin
			@(negedge clock);
			if (memReq) begin
				delay = int'(nextRandom() % 32'd4);
				repeat (delay) @(negedge clock);
				memAck <= 1'b1;
				@(negedge clock);
				while (memReq) @(negedge clock);
				delay = int'(nextRandom() % 32'd4);
				repeat (delay) @(negedge clock);
				memAck <= 1'b0;
			end
		end
	end

	initial begin
		logic lastReq;
		lastReq = 1'b0;
		forever begin
			@(negedge clock);
			if (!reset && !lastReq && memReq && memAck) begin
				otherErrors++;
				$display("Memory request was raised while the acknowledge was still high");
			end
			if (!reset && lastReq && !memReq && !memAck) begin
				otherErrors++;
				$display("Memory request was dropped before the acknowledge arrived");
			end
			lastReq = memReq;
		end
	end

	// Runs one instruction from Fetch up to the next Fetch
	task automatic runInstruction(input OpCode_t op, input Funct_t fn, input AluFlags_t fl);
		logic lastReq;
		logic doneSeen;
		ControlState_t afterDone;
		pathTrace.delete();
		controlTrace.delete();
		storeControls.delete();
		while (state != Fetch) @(negedge clock);
		opCode = op;
		funct = fn;
		flags = fl;
		lastReq = 1'b0;
		doneSeen = 1'b0;
		afterDone = Wait;
		do begin
			if (pathTrace.size() == 0 || pathTrace[pathTrace.size() - 1] != state) begin
				pathTrace.push_back(state);
				controlTrace.push_back(control);
			end
			if (doneSeen) begin
				checkValue("state after memDone", 32'(state), 32'(afterDone));
				doneSeen = 1'b0;
			end
			// memReq falling marks the memDone cycle
			if (lastReq && !memReq) begin
				doneSeen = 1'b1;
				case (state)
					Fetch: afterDone = IrLoad;
					LoadAccess: afterDone = LoadWrite;
					default: afterDone = Wait;
				endcase
			end
			if (memReq && state == StoreAccess) begin
				storeControls.push_back(control);
			end
			lastReq = memReq;
			@(negedge clock);
		end while (state != Fetch || pathTrace.size() < 2);
	endtask

	task automatic expectTail(input ControlState_t s3, s4, s5, s6, input int count);
		ControlState_t expected[7];
		expected = '{Fetch, IrLoad, Decode, s3, s4, s5, s6};
		checkValue("path length", 32'(pathTrace.size()), 32'(count + 3));
		for (int i = 0; i < count + 3 && i < pathTrace.size(); i++) begin
			checkValue($sformatf("state[%0d]", i), 32'(pathTrace[i]), 32'(expected[i]));
		end
	endtask

	task automatic applyReset();
		repeat (4) begin
			@(negedge clock);
			checkValue("memReq", 32'(memReq), 32'd0);
			checkValue("pcWrite", 32'(control.pcWrite), 32'd0);
			checkValue("irWrite", 32'(control.irWrite), 32'd0);
			checkValue("state", 32'(state), 32'(Reset));
		end
		checkValue("regWrite", 32'(control.regWrite), 32'd1);
		checkValue("regDst", 32'(control.regDst), 32'(DstStack));
		checkValue("epcWrite", 32'(control.epcWrite), 32'd1);
		reset = 1'b0;
		@(negedge clock);
		checkValue("state", 32'(state), 32'(Fetch));
	endtask

	task automatic fetchUnderBackPressure();
		repeat (4) begin
			runInstruction(OpCode_t'(6'h3f), FnAdd, NoFlags);
			expectTail(Wait, Wait, Wait, Wait, 1);
			checkValue("irWrite", 32'(controlTrace[1].irWrite), 32'd1);
			checkValue("pcWrite", 32'(controlTrace[1].pcWrite), 32'd1);
		end
	endtask

	task automatic registerInstructions();
		Funct_t fnList[3] = '{FnAdd, FnAnd, FnSub};
		AluOp_t opList[3] = '{AluAdd, AluAnd, AluSub};
		for (int i = 0; i < 3; i++) begin
			runInstruction(Special, fnList[i], NoFlags);
			expectTail(AluReg, WriteReg, Wait, Wait, 3);
			checkValue("aluOp", 32'(controlTrace[3].aluOp), 32'(opList[i]));
			checkValue("regWrite", 32'(controlTrace[4].regWrite), 32'd1);
			checkValue("regDst", 32'(controlTrace[4].regDst), 32'(DstRd));
		end
		runInstruction(Special, FnSlt, NoFlags);
		expectTail(SetLess, Wait, Wait, Wait, 2);
		checkValue("memToReg", 32'(controlTrace[3].memToReg), 32'(FromCompare));
		checkValue("regWrite", 32'(controlTrace[3].regWrite), 32'd1);
		runInstruction(Special, Funct_t'(6'h3f), NoFlags);
		expectTail(Wait, Wait, Wait, Wait, 1);
		foreach (controlTrace[i]) begin
			checkValue("regWrite", 32'(controlTrace[i].regWrite), 32'd0);
		end
	endtask

	task automatic immediateInstructions();
		AluFlags_t fl;
		fl = NoFlags;
		fl.overflow = 1'b1;
		runInstruction(Addi, FnAdd, fl);
		expectTail(AddImm, OverflowExc, Wait, Wait, 3);
		checkValue("epcWrite", 32'(controlTrace[4].epcWrite), 32'd1);
		checkValue("regWrite", 32'(controlTrace[4].regWrite), 32'd0);
		runInstruction(Addi, FnAdd, NoFlags);
		expectTail(AddImm, WriteImm, Wait, Wait, 3);
		checkValue("regDst", 32'(controlTrace[4].regDst), 32'(DstRt));
		// addiu ignores overflow
		runInstruction(Addiu, FnAdd, fl);
		expectTail(AddImm, WriteImm, Wait, Wait, 3);
		checkValue("regWrite", 32'(controlTrace[4].regWrite), 32'd1);
	endtask

	task automatic branchesAndJumps();
		OpCode_t branchOps[4] = '{Beq, Bne, Bgt, Ble};
		AluFlags_t fl;
		logic taken;
		for (int i = 0; i < 4; i++) begin
			for (int c = 0; c < 4; c++) begin
				fl = NoFlags;
				fl.equal = (c >= 2);
				fl.greater = (c % 2 == 1);
				case (branchOps[i])
					Beq: taken = fl.equal;
					Bne: taken = !fl.equal;
					Bgt: taken = fl.greater;
					default: taken = !fl.greater;
				endcase
				runInstruction(branchOps[i], FnAdd, fl);
				expectTail(BranchTarget, BranchCompare, Wait, Wait, 3);
				checkValue("pcWrite", 32'(controlTrace[4].pcWrite), 32'(taken));
				checkValue("pcSource", 32'(controlTrace[4].pcSource), 32'(PcAluOut));
			end
		end
		runInstruction(Special, FnJr, NoFlags);
		expectTail(JumpReg, Wait, Wait, Wait, 2);
		checkValue("pcSource", 32'(controlTrace[3].pcSource), 32'(PcRegister));
		runInstruction(Jump, FnAdd, NoFlags);
		expectTail(JumpTarget, Wait, Wait, Wait, 2);
		checkValue("pcSource", 32'(controlTrace[3].pcSource), 32'(PcJumpTarget));
		runInstruction(Jal, FnAdd, NoFlags);
		expectTail(LinkWrite, JumpTarget, Wait, Wait, 3);
		checkValue("regWrite", 32'(controlTrace[3].regWrite), 32'd1);
		checkValue("regDst", 32'(controlTrace[3].regDst), 32'(DstLink));
		checkValue("pcSource", 32'(controlTrace[4].pcSource), 32'(PcJumpTarget));
	endtask

	task automatic loadsAndStores();
		OpCode_t loadOps[3] = '{Lw, Lh, Lb};
		OpCode_t storeOps[3] = '{Sw, Sh, Sb};
		AccessSize_t sizes[3] = '{SizeWord, SizeHalf, SizeByte};
		for (int i = 0; i < 3; i++) begin
			runInstruction(loadOps[i], FnAdd, NoFlags);
			expectTail(AddrCalc, LoadAccess, LoadWrite, Wait, 4);
			checkValue("memToReg", 32'(controlTrace[5].memToReg), 32'(FromMemory));
			checkValue("accessSize", 32'(controlTrace[5].accessSize), 32'(sizes[i]));
			runInstruction(storeOps[i], FnAdd, NoFlags);
			expectTail(AddrCalc, StoreAccess, Wait, Wait, 3);
			if (storeControls.size() == 0) begin
				otherErrors++;
				$display("Store finished without a memory request");
			end
			foreach (storeControls[k]) begin
				checkValue("memWrite", 32'(storeControls[k].memWrite), 32'd1);
				checkValue("accessSize", 32'(storeControls[k].accessSize), 32'(sizes[i]));
			end
		end
	endtask

	initial begin
		reset = 1'b1;
		opCode = Special;
		funct = FnAdd;
		flags = NoFlags;
		applyReset();
		fetchUnderBackPressure();
		registerInstructions();
		immediateInstructions();
		branchesAndJumps();
		loadsAndStores();
		$display("Value errors: %0d, other errors: %0d", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verification/controlUnit_chk.sv */
`default_nettype none

module controlUnit_chk import controlPkg::*; (
	input logic          clock,
	input logic          reset,
	input logic          memReq,
	input logic          memAck,
	input ControlWord_t  control,
	input ControlState_t state
);

	timeunit 1ns;
	timeprecision 1ps;

	// Four-phase request rules
	requestRise: assert property (@(posedge clock) disable iff (reset)
		$rose(memReq) |-> !$past(memAck))
		else $error("memReq rose while memAck was high");

	requestHold: assert property (@(posedge clock) disable iff (reset)
		memReq && !memAck |=> memReq)
		else $error("memReq dropped before memAck");

	requestDrop: assert property (@(posedge clock) disable iff (reset)
		memReq && memAck |=> !memReq)
		else $error("memReq stayed high after memAck");

	writeExclusive: assert property (@(posedge clock) disable iff (reset)
		!(control.irWrite && control.memWrite))
		else $error("irWrite and memWrite high together");

	fetchNoPcWrite: assert property (@(posedge clock) disable iff (reset)
		state == Fetch |-> !control.pcWrite)
		else $error("pcWrite high during Fetch");

endmodule

bind controlUnit controlUnit_chk chk_i (
	.clock   (clock),
	.reset   (reset),
	.memReq  (memReq),
	.memAck  (memAck),
	.control (control),
	.state   (state)
);

`default_nettype wire

/* logic/controlUnit.sv */
`default_nettype none

module controlUnit import controlPkg::*; (
	input  logic          clock,
	input  logic          reset,
	input  OpCode_t       opCode,
	input  Funct_t        funct,
	input  AluFlags_t     flags,
	input  logic          memAck,
	output logic          memReq,
	output ControlWord_t  control,
	output ControlState_t state
);

	InstrKind_t kind;
	logic memStart;
	logic memDone;

	instructionDecoder decoder_i (
		.opCode (opCode),
		.funct  (funct),
		.kind   (kind)
	);

	controlSequencer sequencer_i (
		.clock    (clock),
		.reset    (reset),
		.kind     (kind),
		.flags    (flags),
		.memDone  (memDone),
		.memStart (memStart),
		.state    (state)
	);

	controlEncoder encoder_i (
		.state   (state),
		.kind    (kind),
		.opCode  (opCode),
		.flags   (flags),
		.control (control)
	);

	memoryHandshake handshake_i (
		.clock    (clock),
		.reset    (reset),
		.memStart (memStart),
		.memAck   (memAck),
		.memReq   (memReq),
		.memDone  (memDone)
	);

endmodule

`default_nettype wire

/* logic/controlEncoder.sv */
`default_nettype none

module controlEncoder import controlPkg::*; (
	input  ControlState_t state,
	input  InstrKind_t    kind,
	input  OpCode_t       opCode,
	input  AluFlags_t     flags,
	output ControlWord_t  control
);

	AccessSize_t accessWidth;
	AluOp_t regAluOp;
	logic branchTaken;

	always_comb begin
		case (opCode)
			Lh,
			Sh: begin
				accessWidth = SizeHalf;
			end
			Lb,
			Sb: begin
				accessWidth = SizeByte;
			end
			default: accessWidth = SizeWord;
		endcase
	end

	always_comb begin
		case (kind)
			InstrAnd: regAluOp = AluAnd;
			InstrSub: regAluOp = AluSub;
			default: regAluOp = AluAdd;
		endcase
	end

	// Branch condition from the compare flags
	always_comb begin
		case (kind)
			InstrBeq: branchTaken = flags.equal;
			InstrBne: branchTaken = !flags.equal;
			InstrBgt: branchTaken = flags.greater;
			InstrBle: branchTaken = !flags.greater;
			default: branchTaken = 1'b0;
		endcase
	end

	always_comb begin
		control = '0;
		case (state)
			Reset: begin
				// Stack pointer and EPC initialisation
				control.regWrite = 1'b1;
				control.regDst = DstStack;
				control.epcWrite = 1'b1;
			end
			Fetch: begin
				control.addrSelect = AddrPc;
				control.memDataWrite = 1'b1;
			end
			IrLoad: begin
				control.irWrite = 1'b1;
				control.pcWrite = 1'b1;
				control.pcSource = PcAluResult;
				control.aluSrcA = SrcAPc;
				control.aluSrcB = SrcBFour;
				control.aluOp = AluAdd;
			end
			Decode: begin
				control.writeRegA = 1'b1;
				control.writeRegB = 1'b1;
			end
			AluReg: begin
				control.aluSrcA = SrcARegA;
				control.aluSrcB = SrcBRegB;
				control.aluOp = regAluOp;
				control.aluOutWrite = 1'b1;
			end
			WriteReg: begin
				control.regWrite = 1'b1;
				control.regDst = DstRd;
				control.memToReg = FromAluOut;
			end
			SetLess: begin
				control.aluSrcA = SrcARegA;
				control.aluOp = AluCompare;
				control.regWrite = 1'b1;
				control.regDst = DstRd;
				control.memToReg = FromCompare;
			end
			AddImm: begin
				control.aluSrcA = SrcARegA;
				control.aluSrcB = SrcBImmediate;
				control.aluOp = AluAdd;
				control.aluOutWrite = 1'b1;
			end
			WriteImm: begin
				control.regWrite = 1'b1;
				control.regDst = DstRt;
			end
			OverflowExc: begin
				control.epcWrite = 1'b1;
				control.addrSelect = AddrExceptionVector;
			end
			BranchTarget: begin
				control.aluSrcA = SrcAPc;
				control.aluSrcB = SrcBBranchOffset;
				control.aluOp = AluAdd;
				control.aluOutWrite = 1'b1;
			end
			BranchCompare: begin
				control.aluSrcA = SrcARegA;
				control.aluOp = AluCompare;
				control.pcSource = PcAluOut;
				control.pcWrite = branchTaken;
			end
			JumpReg: begin
				control.pcWrite = 1'b1;
				control.pcSource = PcRegister;
			end
			JumpTarget: begin
				control.pcWrite = 1'b1;
				control.pcSource = PcJumpTarget;
			end
			LinkWrite: begin
				control.regWrite = 1'b1;
				control.regDst = DstLink;
			end
			AddrCalc: begin
				control.aluSrcA = SrcARegA;
				control.aluSrcB = SrcBImmediate;
				control.aluOp = AluAdd;
				control.aluOutWrite = 1'b1;
			end
			LoadAccess: begin
				control.addrSelect = AddrAluOut;
				control.memDataWrite = 1'b1;
				control.accessSize = accessWidth;
			end
			LoadWrite: begin
				control.regWrite = 1'b1;
				control.regDst = DstRt;
				control.memToReg = FromMemory;
				control.accessSize = accessWidth;
			end
			StoreAccess: begin
				control.addrSelect = AddrAluOut;
				control.memWrite = 1'b1;
				control.accessSize = accessWidth;
			end
			default: control = '0;
		endcase
	end

endmodule

`default_nettype wire

/* logic/controlSequencer.sv */
`default_nettype none

module controlSequencer import controlPkg::*; (
	input  logic          clock,
	input  logic          reset,
	input  InstrKind_t    kind,
	input  AluFlags_t     flags,
	input  logic          memDone,
	output logic          memStart,
	output ControlState_t state
);

	ControlState_t nextState;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= Reset;
		end else begin
			state <= nextState;
		end
	end

	// Memory states keep the request alive until done
	assign memStart = (state == Fetch) || (state == LoadAccess) || (state == StoreAccess);

	always_comb begin
		nextState = state;
		case (state)
			Reset: nextState = Fetch;
			Fetch: begin
				if (memDone) begin
					nextState = IrLoad;
				end
			end
			IrLoad: nextState = Decode;
			Decode: begin
				case (kind)
					InstrAdd,
					InstrAnd,
					InstrSub: begin
						nextState = AluReg;
					end
					InstrSlt: nextState = SetLess;
					InstrAddi,
					InstrAddiu: begin
						nextState = AddImm;
					end
					InstrBeq,
					InstrBne,
					InstrBgt,
					InstrBle: begin
						nextState = BranchTarget;
					end
					InstrJr: nextState = JumpReg;
					InstrJump: nextState = JumpTarget;
					InstrJal: nextState = LinkWrite;
					InstrLoad,
					InstrStore: begin
						nextState = AddrCalc;
					end
					default: nextState = Wait;
				endcase
			end
			AluReg: nextState = WriteReg;
			WriteReg: nextState = Wait;
			SetLess: nextState = Wait;
			AddImm: begin
				// addiu never traps
				if (kind == InstrAddi && flags.overflow) begin
					nextState = OverflowExc;
				end else begin
					nextState = WriteImm;
				end
			end
			WriteImm: nextState = Wait;
			OverflowExc: nextState = Wait;
			BranchTarget: nextState = BranchCompare;
			BranchCompare: nextState = Wait;
			JumpReg: nextState = Wait;
			LinkWrite: nextState = JumpTarget;
			JumpTarget: nextState = Wait;
			AddrCalc: begin
				if (kind == InstrLoad) begin
					nextState = LoadAccess;
				end else begin
					nextState = StoreAccess;
				end
			end
			LoadAccess: begin
				if (memDone) begin
					nextState = LoadWrite;
				end
			end
			LoadWrite: nextState = Wait;
			StoreAccess: begin
				if (memDone) begin
					nextState = Wait;
				end
			end
			Wait: nextState = Fetch;
			default: nextState = Fetch;
		endcase
	end

endmodule

`default_nettype wire

/* logic/memoryHandshake.sv */
`default_nettype none

module memoryHandshake (
	input  logic clock,
	input  logic reset,
	input  logic memStart,
	input  logic memAck,
	output logic memReq,
	output logic memDone
);

	typedef enum logic [1:0] {
		Idle,
		Requesting,
		Releasing
	} HandshakeState_t;

	HandshakeState_t phase;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			phase <= Idle;
			memReq <= 1'b0;
			memDone <= 1'b0;
		end else begin
			memDone <= 1'b0;
			case (phase)
				Idle: begin
					if (memStart && !memAck) begin
						phase <= Requesting;
						memReq <= 1'b1;
					end
				end
				Requesting: begin
					// Hold the request until memory answers
					if (memAck) begin
						phase <= Releasing;
						memReq <= 1'b0;
						memDone <= 1'b1;
					end
				end
				Releasing: begin
					// New starts wait here until ack is gone
					if (!memAck) begin
						phase <= Idle;
					end
				end
				default: begin
					phase <= Idle;
					memReq <= 1'b0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/instructionDecoder.sv */
`default_nettype none

module instructionDecoder import controlPkg::*; (
	input  OpCode_t    opCode,
	input  Funct_t     funct,
	output InstrKind_t kind
);

	always_comb begin
		kind = InstrUnknown;
		case (opCode)
			Special: begin
				// R-type, selected by the function field
				case (funct)
					FnAdd: kind = InstrAdd;
					FnAnd: kind = InstrAnd;
					FnSub: kind = InstrSub;
					FnSlt: kind = InstrSlt;
					FnJr: kind = InstrJr;
					default: kind = InstrUnknown;
				endcase
			end
			Addi: kind = InstrAddi;
			Addiu: kind = InstrAddiu;
			Beq: kind = InstrBeq;
			Bne: kind = InstrBne;
			Bgt: kind = InstrBgt;
			Ble: kind = InstrBle;
			// Width is picked up later from the opcode
			Lw,
			Lh,
			Lb: begin
				kind = InstrLoad;
			end
			Sw,
			Sh,
			Sb: begin
				kind = InstrStore;
			end
			Jump: kind = InstrJump;
			Jal: kind = InstrJal;
			default: kind = InstrUnknown;
		endcase
	end

endmodule

`default_nettype wire

/* logic/controlPkg.sv */
`default_nettype none

package controlPkg;

	// Primary opcodes kept by the unit
	typedef enum logic [5:0] {
		Special = 6'h00,
		Jump    = 6'h02,
		Jal     = 6'h03,
		Beq     = 6'h04,
		Bne     = 6'h05,
		Ble     = 6'h06,
		Bgt     = 6'h07,
		Addi    = 6'h08,
		Addiu   = 6'h09,
		Lb      = 6'h20,
		Lh      = 6'h21,
		Lw      = 6'h23,
		Sb      = 6'h28,
		Sh      = 6'h29,
		Sw      = 6'h2b
	} OpCode_t;

	// Function field of Special
	typedef enum logic [5:0] {
		FnJr  = 6'h08,
		FnAdd = 6'h20,
		FnSub = 6'h22,
		FnAnd = 6'h24,
		FnSlt = 6'h2a
	} Funct_t;

	typedef enum logic [3:0] {
		InstrAdd,
		InstrAnd,
		InstrSub,
		InstrSlt,
		InstrJr,
		InstrAddi,
		InstrAddiu,
		InstrBeq,
		InstrBne,
		InstrBgt,
		InstrBle,
		InstrLoad,
		InstrStore,
		InstrJump,
		InstrJal,
		InstrUnknown
	} InstrKind_t;

	typedef enum logic [4:0] {
		Reset,
		Fetch,
		IrLoad,
		Decode,
		AluReg,
		WriteReg,
		SetLess,
		AddImm,
		WriteImm,
		OverflowExc,
		BranchTarget,
		BranchCompare,
		JumpReg,
		JumpTarget,
		LinkWrite,
		AddrCalc,
		LoadAccess,
		LoadWrite,
		StoreAccess,
		Wait
	} ControlState_t;

	typedef enum logic [2:0] {AluPass, AluAdd, AluSub, AluAnd, AluCompare} AluOp_t;
	typedef enum logic [1:0] {PcAluResult, PcAluOut, PcJumpTarget, PcRegister} PcSource_t;
	typedef enum logic [1:0] {AddrPc, AddrAluOut, AddrExceptionVector} AddrSelect_t;
	typedef enum logic [1:0] {DstRt, DstStack, DstLink, DstRd} RegDst_t;
	typedef enum logic [1:0] {FromAluOut, FromMemory, FromCompare} MemToReg_t;
	typedef enum logic [1:0] {SizeWord, SizeHalf, SizeByte} AccessSize_t;
	typedef enum logic [1:0] {SrcAPc, SrcARegA} AluSrcA_t;
	typedef enum logic [2:0] {SrcBRegB, SrcBFour, SrcBImmediate, SrcBBranchOffset} AluSrcB_t;

	// Everything the datapath needs in one cycle
	typedef struct packed {
		AluSrcA_t    aluSrcA;
		AluSrcB_t    aluSrcB;
		AluOp_t      aluOp;
		PcSource_t   pcSource;
		logic        pcWrite;
		logic        irWrite;
		logic        memWrite;
		AddrSelect_t addrSelect;
		MemToReg_t   memToReg;
		RegDst_t     regDst;
		logic        regWrite;
		logic        writeRegA;
		logic        writeRegB;
		logic        aluOutWrite;
		logic        epcWrite;
		logic        memDataWrite;
		AccessSize_t accessSize;
	} ControlWord_t;

	typedef struct packed {
		logic overflow;
		logic equal;
		logic greater;
	} AluFlags_t;

endpackage

`default_nettype wire
